// File: rtl/kcpu_pkg.sv
/*
  shared types of the microcode control unit
  opcode list is a representative subset, not the full table
  a routine address is {category, step}, 16 steps per routine at most
*/
package kcpu_pkg;

    localparam int OPCAT_AW = 6;
    localparam int STEP_AW  = 4;

    typedef enum logic [7:0] {
        LDA_IMM  = 8'h86,
        ADDA_IMM = 8'h8B,
        SUBA_IMM = 8'h80,
        LDB_IMM  = 8'hC6,
        ADDB_IMM = 8'hCB,
        LDD_IMM  = 8'hCC,
        INCA     = 8'h4C,
        CLRA     = 8'h4F,
        INCB     = 8'h5C,
        CLRB     = 8'h5F,
        LDA_IDX  = 8'hA6,
        CMPX_IDX = 8'hAC,
        LEAX     = 8'h30,
        STA      = 8'hA7,
        STD      = 8'hED,
        BRA      = 8'h20,
        LBRA     = 8'h16,
        JMP      = 8'h0E,
        RTS      = 8'h39,
        NOP      = 8'h12
    } opcode_e;

    typedef enum logic [OPCAT_AW-1:0] {
        // shared routines
        RESET, NMI, FIRQ, IRQ, BUSERROR, PARSE_IDX, IDX_IND,
        // instruction routines
        SINGLE_ALU, SINGLE_ALU_16, SINGLE_A_INH, SINGLE_B_INH, SINGLE_ALU_IDX,
        CMP16_IDX, LEA, STORE8, STORE16, SBRANCH, LBRANCH, JUMP, RTSR, NOPE,
        // index modes, entered from PARSE_IDX
        IDX_RINC, IDX_RINC2, IDX_RDEC, IDX_RDEC2, IDX_R, IDX_OFFSET8,
        IDX_OFFSET16, IDX_EXT, IDX_DP, IDX_ACC
    } op_cat_e;

    typedef struct packed {
        logic ni;               // last step, fetch next opcode
        logic fetch_post;       // consumes the postbyte
        logic idx_jmp;
        logic idx_ret;
        logic skip_noind;
        logic int_en;
        logic we;
        logic set_pc_branch8;
        logic set_pc_branch16;
        logic set_pc_jmp;
        logic up_lda;
        logic up_ldb;
        logic up_ld16;
        logic up_lea;
        logic up_cc;
        logic set_i;
        logic set_f;
        logic psh_pc;
        logic pul_pc;
        logic memhi;
        logic halt;             // stop until reset
    } ctrl_t;

    typedef logic [3:0] intvec_t;  // one hot

    localparam intvec_t INT_NONE  = 4'b0000;
    localparam intvec_t INT_IRQ   = 4'b0001;
    localparam intvec_t INT_FIRQ  = 4'b0010;
    localparam intvec_t INT_NMI   = 4'b0100;
    localparam intvec_t INT_RESET = 4'b1000;

endpackage

// File: rtl/kcpu_dec_if.sv
/*
  decode results between decoder and sequencer
  the sequencer owns the latched opcode and postbyte
*/
`timescale 1ns/1ps

interface kcpu_dec_if;
    logic [7:0]        op_byte;
    logic [7:0]        post_byte;
    kcpu_pkg::op_cat_e opcat;
    kcpu_pkg::op_cat_e nx_cat;   // category to run after the index parse
    kcpu_pkg::op_cat_e idx_cat;
    logic [2:0]        idx_rsel;
    logic [1:0]        idx_asel;
    logic              idx_ind;

    modport dec (input op_byte, input post_byte, output opcat, output nx_cat,
                 output idx_cat, output idx_rsel, output idx_asel, output idx_ind);
    modport seq (output op_byte, output post_byte, input opcat, input nx_cat,
                 input idx_cat, input idx_rsel, input idx_asel, input idx_ind);
endinterface

// File: rtl/kcpu_decode.sv
/*
  combinational decode of the latched opcode and postbyte
  unknown opcodes and illegal postbytes give BUSERROR
  register selects above PC are reserved
*/
`timescale 1ns/1ps

module kcpu_decode (
    kcpu_dec_if.dec dec
);

    localparam logic [2:0] MAX_RSEL = 3'd4;  // X, Y, U, S, PC

    logic uses_reg;

    assign dec.idx_rsel = dec.post_byte[6:4];
    assign dec.idx_asel = dec.post_byte[1:0];
    assign dec.idx_ind  = dec.post_byte[3];

    always_comb begin
        dec.nx_cat = kcpu_pkg::BUSERROR;
        case (kcpu_pkg::opcode_e'(dec.op_byte))
            kcpu_pkg::LDA_IMM, kcpu_pkg::ADDA_IMM, kcpu_pkg::SUBA_IMM,
            kcpu_pkg::LDB_IMM, kcpu_pkg::ADDB_IMM:
                dec.opcat = kcpu_pkg::SINGLE_ALU;
            kcpu_pkg::LDD_IMM:  dec.opcat = kcpu_pkg::SINGLE_ALU_16;
            kcpu_pkg::INCA, kcpu_pkg::CLRA:
                dec.opcat = kcpu_pkg::SINGLE_A_INH;
            kcpu_pkg::INCB, kcpu_pkg::CLRB:
                dec.opcat = kcpu_pkg::SINGLE_B_INH;
            // indexed operand, postbyte parsed first
            kcpu_pkg::LDA_IDX: begin
                dec.opcat  = kcpu_pkg::PARSE_IDX;
                dec.nx_cat = kcpu_pkg::SINGLE_ALU_IDX;
            end
            kcpu_pkg::CMPX_IDX: begin
                dec.opcat  = kcpu_pkg::PARSE_IDX;
                dec.nx_cat = kcpu_pkg::CMP16_IDX;
            end
            kcpu_pkg::LEAX: begin
                dec.opcat  = kcpu_pkg::PARSE_IDX;
                dec.nx_cat = kcpu_pkg::LEA;
            end
            kcpu_pkg::STA: begin
                dec.opcat  = kcpu_pkg::PARSE_IDX;
                dec.nx_cat = kcpu_pkg::STORE8;
            end
            kcpu_pkg::STD: begin
                dec.opcat  = kcpu_pkg::PARSE_IDX;
                dec.nx_cat = kcpu_pkg::STORE16;
            end
            kcpu_pkg::BRA:  dec.opcat = kcpu_pkg::SBRANCH;
            kcpu_pkg::LBRA: dec.opcat = kcpu_pkg::LBRANCH;
            kcpu_pkg::JMP:  dec.opcat = kcpu_pkg::JUMP;
            kcpu_pkg::RTS:  dec.opcat = kcpu_pkg::RTSR;
            kcpu_pkg::NOP:  dec.opcat = kcpu_pkg::NOPE;
            default:        dec.opcat = kcpu_pkg::BUSERROR;
        endcase
    end

    // index mode from bit 7 and bits 2..0
    always_comb begin
        case ({dec.post_byte[7], dec.post_byte[2:0]})
            4'b0_000: dec.idx_cat = kcpu_pkg::IDX_RINC;
            4'b0_001: dec.idx_cat = kcpu_pkg::IDX_RINC2;
            4'b0_010: dec.idx_cat = kcpu_pkg::IDX_RDEC;
            4'b0_011: dec.idx_cat = kcpu_pkg::IDX_RDEC2;
            4'b0_100: dec.idx_cat = kcpu_pkg::IDX_OFFSET8;
            4'b0_101: dec.idx_cat = kcpu_pkg::IDX_OFFSET16;
            4'b0_110: dec.idx_cat = kcpu_pkg::IDX_R;
            4'b0_111: dec.idx_cat = kcpu_pkg::IDX_EXT;
            4'b1_100: dec.idx_cat = kcpu_pkg::IDX_DP;
            default: begin
                // A, B or D offset; D takes the 111 code, 10 is reserved
                if (dec.post_byte[7] && dec.idx_asel != 2'b10
                        && dec.post_byte[2] == (dec.idx_asel == 2'b11)) begin
                    dec.idx_cat = kcpu_pkg::IDX_ACC;
                end else begin
                    dec.idx_cat = kcpu_pkg::BUSERROR;
                end
            end
        endcase
        uses_reg = dec.idx_cat != kcpu_pkg::IDX_EXT && dec.idx_cat != kcpu_pkg::IDX_DP;
        if (uses_reg && dec.idx_rsel > MAX_RSEL) begin
            dec.idx_cat = kcpu_pkg::BUSERROR;  // reserved register
        end
    end

endmodule

// File: rtl/kcpu_ucode_rom.sv
/*
  microcode table, one control word per category and step
  words past the end of a routine are all zero and never reached
  interrupt and reset routines keep int_en high on every step
*/
`timescale 1ns/1ps

module kcpu_ucode_rom (
    input  kcpu_pkg::op_cat_e            cat,
    input  logic [kcpu_pkg::STEP_AW-1:0] step,
    output kcpu_pkg::ctrl_t              ctrl
);

    logic s0;
    logic s1;
    logic s2;

    assign s0 = step == kcpu_pkg::STEP_AW'(0);
    assign s1 = step == kcpu_pkg::STEP_AW'(1);
    assign s2 = step == kcpu_pkg::STEP_AW'(2);

    always_comb begin
        ctrl = '0;
        case (cat)
            kcpu_pkg::RESET: begin
                ctrl.int_en     = 1'b1;
                ctrl.set_i      = s0;
                ctrl.set_f      = s0;
                ctrl.set_pc_jmp = s1;  // load reset vector
                ctrl.ni         = s1;
            end
            kcpu_pkg::NMI, kcpu_pkg::FIRQ, kcpu_pkg::IRQ: begin
                ctrl.int_en     = 1'b1;
                ctrl.psh_pc     = s0;
                ctrl.set_i      = s1;
                ctrl.set_f      = s1 && cat != kcpu_pkg::IRQ;  // irq leaves F alone
                ctrl.set_pc_jmp = s2;
                ctrl.ni         = s2;
            end
            kcpu_pkg::SINGLE_ALU, kcpu_pkg::SINGLE_ALU_IDX: begin
                ctrl.up_lda = s0;
                ctrl.up_cc  = s1;
                ctrl.ni     = s1;
            end
            kcpu_pkg::SINGLE_ALU_16: begin
                ctrl.memhi   = s0;
                ctrl.up_ld16 = s1;
                ctrl.up_cc   = s2;
                ctrl.ni      = s2;
            end
            kcpu_pkg::SINGLE_A_INH: begin
                ctrl.up_lda = s0;
                ctrl.up_cc  = s0;
                ctrl.ni     = s0;
            end
            kcpu_pkg::SINGLE_B_INH: begin
                ctrl.up_ldb = s0;
                ctrl.up_cc  = s0;
                ctrl.ni     = s0;
            end
            kcpu_pkg::NOPE: ctrl.ni = s0;
            kcpu_pkg::SBRANCH: begin
                ctrl.set_pc_branch8 = s0;
                ctrl.ni             = s1;
            end
            kcpu_pkg::LBRANCH: begin
                ctrl.memhi           = s0;  // offset high byte
                ctrl.set_pc_branch16 = s1;
                ctrl.ni              = s2;
            end
            kcpu_pkg::JUMP: begin
                ctrl.set_pc_jmp = s0;
                ctrl.ni         = s1;
            end
            kcpu_pkg::RTSR: begin
                ctrl.pul_pc = s0;
                ctrl.ni     = s1;
            end
            kcpu_pkg::PARSE_IDX: begin
                ctrl.fetch_post = s0;
                ctrl.idx_jmp    = s0;
            end
            kcpu_pkg::IDX_RINC: begin
                ctrl.skip_noind = s0;
                ctrl.memhi      = s1;  // indirect pointer only
                ctrl.idx_ret    = s2;
            end
            kcpu_pkg::IDX_OFFSET16, kcpu_pkg::IDX_EXT, kcpu_pkg::IDX_IND: begin
                ctrl.memhi   = s0;
                ctrl.idx_ret = s1;
            end
            kcpu_pkg::IDX_RINC2, kcpu_pkg::IDX_RDEC, kcpu_pkg::IDX_RDEC2, kcpu_pkg::IDX_R,
            kcpu_pkg::IDX_OFFSET8, kcpu_pkg::IDX_DP, kcpu_pkg::IDX_ACC: begin
                ctrl.idx_ret = s0;
            end
            kcpu_pkg::CMP16_IDX: begin
                ctrl.memhi = s0;
                ctrl.up_cc = s1;
                ctrl.ni    = s1;
            end
            kcpu_pkg::LEA: begin
                ctrl.up_lea = s0;
                ctrl.up_cc  = s1;
                ctrl.ni     = s1;
            end
            kcpu_pkg::STORE8: begin
                ctrl.we    = s0;
                ctrl.up_cc = s1;
                ctrl.ni    = s1;
            end
            kcpu_pkg::STORE16: begin
                ctrl.we    = s0 | s1;
                ctrl.memhi = s0;
                ctrl.up_cc = s2;
                ctrl.ni    = s2;
            end
            kcpu_pkg::BUSERROR: ctrl.halt = s0;
            default: ctrl = '0;
        endcase
    end

endmodule

// File: rtl/kcpu_ucode_seq.sv
/*
  microcode address sequencer
  a uop with ni or fetch_post waits for a byte and takes it on acceptance
  the new category shows one cycle after a fetch, so uop_valid drops meanwhile
  USE_IRQ = 0 ignores nmi_n, firq_n and irq_n
  after a halt step only rst restarts the unit
*/
`timescale 1ns/1ps

module kcpu_ucode_seq #(
    parameter bit USE_IRQ = 1'b1
) (
    input  logic                         clk,
    input  logic                         rst,
    kcpu_dec_if.seq                      dec,
    output kcpu_pkg::op_cat_e            cur_cat,
    output logic [kcpu_pkg::STEP_AW-1:0] cur_step,
    input  kcpu_pkg::ctrl_t              ctrl,
    input  logic                         byte_valid,
    output logic                         byte_ready,
    input  logic [7:0]                   byte_data,
    output logic                         uop_valid,
    input  logic                         uop_ready,
    input  logic                         irq_n,
    input  logic                         firq_n,
    input  logic                         nmi_n,
    output kcpu_pkg::intvec_t            intvec,
    output logic                         bus_error
);

    typedef enum logic [2:0] {ST_IDLE, ST_RUN, ST_OPDEC, ST_IDXDEC, ST_HALT} state_e;

    state_e                       state;
    kcpu_pkg::op_cat_e            nx_pend;   // category after the index parse
    logic                         ind_pend;  // indirect bit of the postbyte
    kcpu_pkg::intvec_t            cur_int;
    logic                         need_byte;
    logic                         fire;
    logic [kcpu_pkg::STEP_AW-1:0] step_inc;

    assign need_byte  = ctrl.ni | ctrl.fetch_post;
    assign uop_valid  = state == ST_RUN && (byte_valid || !need_byte);
    assign fire       = uop_valid && uop_ready;
    assign byte_ready = fire && need_byte;  // byte goes with its uop
    assign bus_error  = state == ST_HALT;
    assign intvec     = ctrl.int_en ? cur_int : kcpu_pkg::INT_NONE;
    assign step_inc   = (ctrl.skip_noind && !ind_pend) ? kcpu_pkg::STEP_AW'(2)
                                                       : kcpu_pkg::STEP_AW'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            cur_cat  <= kcpu_pkg::RESET;
            cur_step <= '0;
            cur_int  <= kcpu_pkg::INT_RESET;
            ind_pend <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: state <= ST_RUN;
                ST_OPDEC: begin  // latched opcode decoded by now
                    cur_cat  <= dec.opcat;
                    cur_step <= '0;
                    state    <= ST_RUN;
                end
                ST_IDXDEC: begin
                    cur_cat  <= dec.idx_cat;
                    cur_step <= '0;
                    ind_pend <= dec.idx_ind;
                    state    <= ST_RUN;
                end
                ST_RUN: begin
                    if (fire) begin
                        cur_step <= cur_step + step_inc;
                        if (ctrl.halt) state <= ST_HALT;
                        if (ctrl.idx_jmp) state <= ST_IDXDEC;
                        if (ctrl.idx_ret) begin
                            cur_step <= '0;
                            if (ind_pend) begin  // fetch pointer first
                                cur_cat  <= kcpu_pkg::IDX_IND;
                                ind_pend <= 1'b0;
                            end else begin
                                cur_cat <= nx_pend;
                            end
                        end
                        if (ctrl.ni) begin
                            cur_step <= '0;
                            if (USE_IRQ && !nmi_n) begin
                                cur_int <= kcpu_pkg::INT_NMI;
                                cur_cat <= kcpu_pkg::NMI;
                            end else if (USE_IRQ && !firq_n) begin
                                cur_int <= kcpu_pkg::INT_FIRQ;
                                cur_cat <= kcpu_pkg::FIRQ;
                            end else if (USE_IRQ && !irq_n) begin
                                cur_int <= kcpu_pkg::INT_IRQ;
                                cur_cat <= kcpu_pkg::IRQ;
                            end else begin
                                cur_int <= kcpu_pkg::INT_NONE;
                                state   <= ST_OPDEC;
                            end
                        end
                    end
                end
                default: state <= ST_HALT;  // held until rst
            endcase
        end
    end

    // latched bytes, opcode byte dropped when an interrupt wins
    always_ff @(posedge clk) begin
        if (fire && ctrl.ni) dec.op_byte <= byte_data;
        if (fire && ctrl.fetch_post) dec.post_byte <= byte_data;
        if (state == ST_OPDEC) nx_pend <= dec.nx_cat;
    end

endmodule

// File: rtl/kcpu_ctrl.sv
/*
  microcode control unit top level
  fetch stream in, one control word per step out, both valid/ready
  datapath, memory and branch conditions are outside this unit
*/
`timescale 1ns/1ps

module kcpu_ctrl #(
    parameter bit USE_IRQ = 1'b1
) (
    input  logic                         clk,
    input  logic                         rst,
    // fetch stream
    input  logic                         byte_valid,
    output logic                         byte_ready,
    input  logic [7:0]                   byte_data,
    // microinstruction stream
    output logic                         uop_valid,
    input  logic                         uop_ready,
    output kcpu_pkg::op_cat_e            uop_cat,
    output logic [kcpu_pkg::STEP_AW-1:0] uop_step,
    output kcpu_pkg::ctrl_t              uop_ctrl,
    input  logic                         irq_n,
    input  logic                         firq_n,
    input  logic                         nmi_n,
    output kcpu_pkg::intvec_t            intvec,
    output logic                         bus_error
);

    kcpu_dec_if dec_if ();

    kcpu_decode decode_i (
        .dec (dec_if)
    );

    kcpu_ucode_rom rom_i (
        .cat  (uop_cat),
        .step (uop_step),
        .ctrl (uop_ctrl)
    );

    kcpu_ucode_seq #(
        .USE_IRQ (USE_IRQ)
    ) seq_i (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec_if),
        .cur_cat    (uop_cat),
        .cur_step   (uop_step),
        .ctrl       (uop_ctrl),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .byte_data  (byte_data),
        .uop_valid  (uop_valid),
        .uop_ready  (uop_ready),
        .irq_n      (irq_n),
        .firq_n     (firq_n),
        .nmi_n      (nmi_n),
        .intvec     (intvec),
        .bus_error  (bus_error)
    );

endmodule

// File: test/kcpu_ctrl_checker.sv
/*
  handshake assertions bound into the control unit top level
  checks stream stability, the sticky bus error and quiet outputs after rst
*/
`timescale 1ns/1ps

module kcpu_ctrl_checker (
    input logic                         clk,
    input logic                         rst,
    input logic                         byte_valid,
    input logic                         byte_ready,
    input logic [7:0]                   byte_data,
    input logic                         uop_valid,
    input logic                         uop_ready,
    input kcpu_pkg::op_cat_e            uop_cat,
    input logic [kcpu_pkg::STEP_AW-1:0] uop_step,
    input kcpu_pkg::ctrl_t              uop_ctrl,
    input logic                         bus_error
);

    uop_hold: assert property (@(posedge clk) disable iff (rst)
        uop_valid && !uop_ready |=> uop_valid && $stable(uop_cat)
            && $stable(uop_step) && $stable(uop_ctrl))
        else $error("uop dropped or changed before acceptance");

    byte_hold: assert property (@(posedge clk) disable iff (rst)
        byte_valid && !byte_ready |=> byte_valid && $stable(byte_data))
        else $error("fetch byte dropped or changed before acceptance");

    err_sticky: assert property (@(posedge clk) bus_error && !rst |=> bus_error)
        else $error("bus_error fell without rst");

    // state is cleared one edge into rst
    rst_quiet: assert property (@(posedge clk) rst |=> !uop_valid && !byte_ready)
        else $error("handshake active during rst");

endmodule

bind kcpu_ctrl kcpu_ctrl_checker checker_i (
    .clk(clk), .rst(rst), .byte_valid(byte_valid), .byte_ready(byte_ready),
    .byte_data(byte_data), .uop_valid(uop_valid), .uop_ready(uop_ready),
    .uop_cat(uop_cat), .uop_step(uop_step), .uop_ctrl(uop_ctrl),
    .bus_error(bus_error)
);

// File: test/tb_kcpu_ctrl.sv
/*
  directed testbench for the microcode control unit
  opcode and postbyte bytes only, operand bytes are not part of the fetch stream
  expected traces come from fixed routine lengths per category
*/
`timescale 1ns/1ps

module tb_kcpu_ctrl;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         byte_valid;
    logic                         byte_ready;
    logic [7:0]                   byte_data;
    logic                         uop_valid;
    logic                         uop_ready;
    kcpu_pkg::op_cat_e            uop_cat;
    logic [kcpu_pkg::STEP_AW-1:0] uop_step;
    kcpu_pkg::ctrl_t              uop_ctrl;
    logic                         irq_n;
    logic                         firq_n;
    logic                         nmi_n;
    kcpu_pkg::intvec_t            intvec;
    logic                         bus_error;

    logic [7:0]                   byte_q[$];
    kcpu_pkg::op_cat_e            cap_cat[$];
    logic [kcpu_pkg::STEP_AW-1:0] cap_step[$];
    kcpu_pkg::ctrl_t              cap_ctrl[$];
    kcpu_pkg::intvec_t            cap_vec[$];
    bit                           cap_take[$];
    kcpu_pkg::op_cat_e            exp_cat[$];
    int                           exp_step[$];
    bit                           exp_take[$];
    kcpu_pkg::intvec_t            exp_vec[$];
    bit                           gaps;
    bit                           took;
    int                           bytes_taken;
    int                           value_errs;
    int                           other_errs;

    kcpu_ctrl #(.USE_IRQ(1'b1)) dut_i (
        .clk(clk), .rst(rst), .byte_valid(byte_valid), .byte_ready(byte_ready),
        .byte_data(byte_data), .uop_valid(uop_valid), .uop_ready(uop_ready),
        .uop_cat(uop_cat), .uop_step(uop_step), .uop_ctrl(uop_ctrl),
        .irq_n(irq_n), .firq_n(firq_n), .nmi_n(nmi_n), .intvec(intvec),
        .bus_error(bus_error)
    );

    always #4 clk = ~clk;

    // monitor at the edge, then fetch driver and ready gaps 1 ns later
    always @(posedge clk) begin
        took = 1'b0;
        if (!rst && uop_valid && uop_ready) begin
            cap_cat.push_back(uop_cat);
            cap_step.push_back(uop_step);
            cap_ctrl.push_back(uop_ctrl);
            cap_vec.push_back(intvec);
            cap_take.push_back(byte_ready);
        end
        if (!rst && byte_valid && byte_ready) begin
            void'(byte_q.pop_front());
            bytes_taken++;
            took = 1'b1;
        end
        #1;
        uop_ready = gaps ? ($urandom % 4 != 0) : 1'b1;
        if (!(byte_valid && !took) || byte_q.size() == 0) begin  // offered byte holds
            byte_valid = byte_q.size() > 0 && (!gaps || $urandom % 3 != 0);
        end
        byte_data = byte_q.size() > 0 ? byte_q[0] : 8'h00;
    end

    task automatic check_cat(kcpu_pkg::op_cat_e got, kcpu_pkg::op_cat_e exp, int idx);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0t: uop %0d category %s, expected %s",
                     $time, idx, got.name(), exp.name());
        end
    endtask

    task automatic check_step(logic [kcpu_pkg::STEP_AW-1:0] got, int exp, int idx);
        if (got !== kcpu_pkg::STEP_AW'(exp)) begin
            value_errs++;
            $display("** Error at %0t: uop %0d step %0d, expected %0d", $time, idx, got, exp);
        end
    endtask

    task automatic check_ctrl_bit(kcpu_pkg::ctrl_t c, string field, logic exp, int idx);
        logic got;
        case (field)
            "ni":         got = c.ni;
            "fetch_post": got = c.fetch_post;
            "halt":       got = c.halt;
            default:      got = 1'bx;  // unknown field never matches
        endcase
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0t: uop %0d ctrl %s is %b, expected %b",
                     $time, idx, field, got, exp);
        end
    endtask

    task automatic check_vec(kcpu_pkg::intvec_t got, kcpu_pkg::intvec_t exp, int idx);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0t: uop %0d intvec %b, expected %b", $time, idx, got, exp);
        end
    endtask

    task automatic expect_step(kcpu_pkg::op_cat_e cat, int step, bit take);
        exp_cat.push_back(cat);
        exp_step.push_back(step);
        exp_take.push_back(take);
        case (cat)
            kcpu_pkg::RESET: exp_vec.push_back(4'b1000);
            kcpu_pkg::NMI:   exp_vec.push_back(4'b0100);
            kcpu_pkg::FIRQ:  exp_vec.push_back(4'b0010);
            kcpu_pkg::IRQ:   exp_vec.push_back(4'b0001);
            default:         exp_vec.push_back(4'b0000);
        endcase
    endtask

    // steps count up from 0 and the last one fetches when take is set
    task automatic expect_routine(kcpu_pkg::op_cat_e cat, int len, bit take);
        for (int s = 0; s < len; s++) begin
            expect_step(cat, s, take && s == len - 1);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        gaps = 1'b0;
        byte_q.delete();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        cap_cat.delete();
        cap_step.delete();
        cap_ctrl.delete();
        cap_vec.delete();
        cap_take.delete();
        exp_cat.delete();
        exp_step.delete();
        exp_take.delete();
        exp_vec.delete();
        bytes_taken = 0;
        #1;
    endtask

    task automatic wait_uops(int n, int limit, string what);
        int k;
        k = 0;
        while (cap_cat.size() < n && k < limit) begin
            @(posedge clk);
            k++;
        end
        if (cap_cat.size() < n) begin
            other_errs++;
            $display("timeout: %s got %0d accepted uops, wanted %0d", what, cap_cat.size(), n);
        end
    endtask

    // settle, then compare the whole accepted trace with the expected one
    task automatic verify_trace(string what);
        int n;
        int fetches;
        wait_uops(exp_cat.size(), 400, what);
        repeat (6) @(posedge clk);
        fetches = 0;
        if (cap_cat.size() != exp_cat.size()) begin
            other_errs++;
            $display("%s: %0d uops accepted where %0d were expected",
                     what, cap_cat.size(), exp_cat.size());
        end
        n = cap_cat.size() < exp_cat.size() ? cap_cat.size() : exp_cat.size();
        for (int i = 0; i < n; i++) begin
            check_cat(cap_cat[i], exp_cat[i], i);
            check_step(cap_step[i], exp_step[i], i);
            check_ctrl_bit(cap_ctrl[i], "ni",
                           exp_take[i] && exp_cat[i] != kcpu_pkg::PARSE_IDX, i);
            check_ctrl_bit(cap_ctrl[i], "fetch_post", exp_cat[i] == kcpu_pkg::PARSE_IDX, i);
            check_ctrl_bit(cap_ctrl[i], "halt", exp_cat[i] == kcpu_pkg::BUSERROR, i);
            check_vec(cap_vec[i], exp_vec[i], i);
            if (cap_take[i] != exp_take[i]) begin
                other_errs++;
                $display("%s: byte handshake out of step with uop %0d", what, i);
            end
            fetches += exp_take[i];
        end
        if (bytes_taken != fetches) begin
            other_errs++;
            $display("%s: %0d bytes consumed, expected %0d", what, bytes_taken, fetches);
        end
    endtask

    task automatic plain_opcodes(bit with_gaps);
        apply_reset();
        gaps = with_gaps;
        byte_q = '{kcpu_pkg::LDA_IMM, kcpu_pkg::INCA, kcpu_pkg::NOP, kcpu_pkg::NOP};
        expect_routine(kcpu_pkg::RESET, 2, 1'b1);
        expect_routine(kcpu_pkg::SINGLE_ALU, 2, 1'b1);
        expect_routine(kcpu_pkg::SINGLE_A_INH, 1, 1'b1);
        expect_routine(kcpu_pkg::NOPE, 1, 1'b1);
        verify_trace(with_gaps ? "plain opcodes with gaps" : "plain opcodes");
    endtask

    task automatic index_case(logic [7:0] post, kcpu_pkg::op_cat_e mode, int len, bit ind);
        apply_reset();
        byte_q = '{kcpu_pkg::LDA_IDX, post, kcpu_pkg::NOP};
        expect_routine(kcpu_pkg::RESET, 2, 1'b1);
        expect_routine(kcpu_pkg::PARSE_IDX, 1, 1'b1);
        if (mode == kcpu_pkg::IDX_RINC && !ind) begin
            expect_step(mode, 0, 1'b0);
            expect_step(mode, 2, 1'b0);  // pointer fetch skipped
        end else begin
            expect_routine(mode, len, 1'b0);
        end
        if (ind) expect_routine(kcpu_pkg::IDX_IND, 2, 1'b0);
        expect_routine(kcpu_pkg::SINGLE_ALU_IDX, 2, 1'b1);
        verify_trace("indexed path");
    endtask

    task automatic irq_case(logic n, logic f, logic i, kcpu_pkg::op_cat_e cat);
        apply_reset();
        {nmi_n, firq_n, irq_n} = {n, f, i};
        byte_q = '{kcpu_pkg::NOP, kcpu_pkg::NOP, kcpu_pkg::NOP};
        expect_routine(kcpu_pkg::RESET, 2, 1'b1);
        expect_routine(cat, 3, 1'b1);
        expect_routine(kcpu_pkg::NOPE, 1, 1'b1);
        wait_uops(2, 100, "interrupt entry");
        #1;
        {nmi_n, firq_n, irq_n} = 3'b111;
        verify_trace("interrupt priority");
    endtask

    task automatic bus_error_case(bit bad_post);
        int k;
        apply_reset();
        expect_routine(kcpu_pkg::RESET, 2, 1'b1);
        if (bad_post) begin
            byte_q = '{kcpu_pkg::LDA_IDX, 8'h82};  // accumulator code 10 is reserved
            expect_routine(kcpu_pkg::PARSE_IDX, 1, 1'b1);
        end else begin
            byte_q = '{8'h01};
        end
        expect_routine(kcpu_pkg::BUSERROR, 1, 1'b0);
        verify_trace("bus error");
        for (k = 0; k < 20; k++) begin
            @(posedge clk);
            if (bus_error !== 1'b1 || cap_cat.size() != exp_cat.size()) begin
                other_errs++;
                $display("bus error: halt not kept, bus_error=%b", bus_error);
                break;
            end
        end
        apply_reset();
        @(posedge clk);
        if (bus_error !== 1'b0) begin
            other_errs++;
            $display("bus error: still set after a new reset");
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(32'h3117_339e));
        rst = 1'b1;
        byte_valid = 1'b0;
        byte_data = 8'h00;
        uop_ready = 1'b0;
        {nmi_n, firq_n, irq_n} = 3'b111;
        plain_opcodes(1'b0);
        index_case(8'h06, kcpu_pkg::IDX_R, 1, 1'b0);
        index_case(8'h04, kcpu_pkg::IDX_OFFSET8, 1, 1'b0);
        index_case(8'h07, kcpu_pkg::IDX_EXT, 2, 1'b0);
        index_case(8'h80, kcpu_pkg::IDX_ACC, 1, 1'b0);
        index_case(8'h0E, kcpu_pkg::IDX_R, 1, 1'b1);
        index_case(8'h00, kcpu_pkg::IDX_RINC, 3, 1'b0);
        index_case(8'h08, kcpu_pkg::IDX_RINC, 3, 1'b1);
        irq_case(1'b0, 1'b0, 1'b0, kcpu_pkg::NMI);
        irq_case(1'b1, 1'b0, 1'b0, kcpu_pkg::FIRQ);
        irq_case(1'b1, 1'b1, 1'b0, kcpu_pkg::IRQ);
        plain_opcodes(1'b1);
        bus_error_case(1'b0);
        bus_error_case(1'b1);
        finish_run();
    end

endmodule

// File: all.f
rtl/kcpu_pkg.sv
rtl/kcpu_dec_if.sv
rtl/kcpu_decode.sv
rtl/kcpu_ucode_rom.sv
rtl/kcpu_ucode_seq.sv
rtl/kcpu_ctrl.sv
test/kcpu_ctrl_checker.sv
test/tb_kcpu_ctrl.sv

// File: run.sh
#!/bin/sh
# build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_kcpu_ctrl -f all.f -o sim_kcpu

if ! ./obj_dir/sim_kcpu > sim.log 2>&1; then
    cat sim.log
    echo "simulator exited with an error"
    exit 1
fi
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
